// File: build.f
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/apb_host_port.sv
hw/run_control.sv
hw/cycle_timer.sv
hw/register_file.sv
hw/data_memory.sv
hw/cpu.sv
hw/cpu_top.sv
bench/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - files:
      - hw/cpu_isa_pkg.sv
      - hw/cpu_bus_pkg.sv
      - hw/apb_host_port.sv
      - hw/run_control.sv
      - hw/cycle_timer.sv
      - hw/register_file.sv
      - hw/data_memory.sv
      - hw/cpu.sv
      - hw/cpu_top.sv
  - target: simulation
    files:
      - bench/cpu_tb.sv

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  localparam int cycle_limit = 300;
  localparam int dmem_words  = 64;
  // six runs at the limit at most plus program loads and register reads
  localparam int timeout_cycles = 6 * cycle_limit + 3200;
  localparam word_t halt_word = {op_halt, 12'h000};

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  logic      pready;
  logic      pslverr;
  logic      complete;
  apb_addr_t paddr;
  word_t     pwdata;
  word_t     prdata;
  int        errors;
  int        cycle_count;
  word_t     prog[$];
  word_t     exp_regs[8];
  word_t     exp_mem[dmem_words];

  cpu_top #(.imem_depth(64), .dmem_depth(dmem_words), .cycle_limit(cycle_limit)) u_dut (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .complete(complete)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  ////////////////////
  // APB driver

  task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;
    if (pready !== 1'b1) report_error($sformatf("pready low in write access to %h", addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    if (pready !== 1'b1) report_error($sformatf("pready low in read access to %h", addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  ////////////////////
  // program builder and ISA model

  function automatic word_t alu_word(opcode_e op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op, rs, rt, rd, 3'b000};
  endfunction

  function automatic word_t imm_word(opcode_e op, reg_addr_t rs, reg_addr_t rt, logic [5:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jump_word(logic [11:0] target);
    return {op_jmp, target};
  endfunction

  // executes prog one instruction at a time in program order
  task automatic run_model();
    int    pc;
    int    steps;
    word_t w;
    word_t a;
    word_t b;
    word_t imm;
    word_t dmem_addr;
    pc    = 0;
    steps = 0;
    while (pc < prog.size() && steps < 500) begin
      w         = prog[pc];
      a         = exp_regs[w[rs_msb:rs_lsb]];
      b         = exp_regs[w[rt_msb:rt_lsb]];
      imm       = word_t'(w[imm_msb:imm_lsb]);
      dmem_addr = (a + imm) % dmem_words;
      pc++;
      steps++;
      case (opcode_e'(w[opcode_msb:opcode_lsb]))
        op_add:  exp_regs[w[rd_msb:rd_lsb]] = a + b;
        op_sub:  exp_regs[w[rd_msb:rd_lsb]] = a - b;
        op_and:  exp_regs[w[rd_msb:rd_lsb]] = a & b;
        op_or:   exp_regs[w[rd_msb:rd_lsb]] = a | b;
        op_slt:  exp_regs[w[rd_msb:rd_lsb]] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        op_addi: exp_regs[w[rt_msb:rt_lsb]] = a + imm;
        op_lw:   exp_regs[w[rt_msb:rt_lsb]] = exp_mem[dmem_addr];
        op_sw:   exp_mem[dmem_addr] = b;
        op_beq:  if (a == b) pc = int'(imm);
        op_bne:  if (a != b) pc = int'(imm);
        op_jmp:  pc = int'(w[jump_msb:0]);
        op_halt: pc = prog.size();
        default: ;
      endcase
      // r0 is hardwired to zero
      exp_regs[0] = '0;
    end
  endtask

  // trailing nops keep unwritten words out of the fetch path
  task automatic load_program();
    logic err;
    repeat (3) prog.push_back(nop_instr);
    for (int i = 0; i < prog.size(); i++) begin
      apb_write(addr_imem_base + apb_addr_t'(4 * i), prog[i], err);
      if (err !== 1'b0) report_error($sformatf("pslverr on program word %0d", i));
    end
    prog.delete();
  endtask

  task automatic start_run();
    logic err;
    apb_write(addr_ctrl, 16'h0001, err);
    if (err !== 1'b0) report_error("pslverr on start write");
  endtask

  task automatic wait_complete();
    while (complete !== 1'b1) @(negedge clk);
  endtask

  task automatic run_and_wait();
    start_run();
    wait_complete();
  endtask

  ////////////////////
  // checks

  task automatic check_regs(input string label);
    word_t data;
    logic  err;
    for (int i = 0; i < 8; i++) begin
      apb_read(addr_reg_base + apb_addr_t'(4 * i), data, err);
      if (data !== exp_regs[i] || err !== 1'b0)
        report_error($sformatf("%s r%0d is %h, expected %h", label, i, data, exp_regs[i]));
    end
  endtask

  task automatic check_read(input string label, input apb_addr_t addr, input word_t expected);
    word_t data;
    logic  err;
    apb_read(addr, data, err);
    if (data !== expected || err !== 1'b0)
      report_error($sformatf("%s is %h, expected %h", label, data, expected));
  endtask

  ////////////////////
  // directed tests

  task automatic test_reset();
    foreach (exp_regs[i]) exp_regs[i] = '0;
    if (complete !== 1'b0) report_error("complete is high after reset");
    check_read("status after reset", addr_ctrl, 16'h0000);
    check_regs("reset");
  endtask

  task automatic test_arith();
    word_t data;
    logic  err;
    prog.push_back(imm_word(op_addi, 0, 1, 12));
    prog.push_back(imm_word(op_addi, 1, 2, 9));
    prog.push_back(alu_word(op_add, 3, 1, 2));
    prog.push_back(alu_word(op_sub, 4, 3, 1));
    prog.push_back(alu_word(op_and, 5, 4, 1));
    prog.push_back(alu_word(op_or, 6, 5, 3));
    prog.push_back(alu_word(op_sub, 7, 1, 3));
    prog.push_back(alu_word(op_slt, 6, 7, 1));
    prog.push_back(alu_word(op_add, 0, 1, 2));
    prog.push_back(halt_word);
    run_model();
    load_program();
    run_and_wait();
    check_read("arith status", addr_ctrl, word_t'(1 << status_done));
    check_regs("arith");
    check_read("arith r0", addr_reg_base, 16'h0000);
    apb_read(addr_cycles, data, err);
    if (data == 0 || data >= cycle_limit)
      report_error($sformatf("arith cycle count %0d not below limit %0d", data, cycle_limit));
  endtask

  task automatic test_memory();
    prog.push_back(imm_word(op_addi, 0, 1, 20));
    prog.push_back(imm_word(op_addi, 0, 2, 45));
    prog.push_back(imm_word(op_sw, 1, 2, 0));
    prog.push_back(imm_word(op_addi, 0, 3, 9));
    prog.push_back(imm_word(op_sw, 1, 3, 3));
    // each load feeds the next instruction
    prog.push_back(imm_word(op_lw, 1, 4, 0));
    prog.push_back(alu_word(op_add, 5, 4, 3));
    prog.push_back(imm_word(op_lw, 1, 6, 3));
    prog.push_back(alu_word(op_sub, 7, 6, 2));
    prog.push_back(imm_word(op_lw, 1, 2, 3));
    prog.push_back(imm_word(op_sw, 1, 2, 5));
    prog.push_back(imm_word(op_lw, 1, 3, 5));
    prog.push_back(imm_word(op_addi, 3, 3, 1));
    prog.push_back(halt_word);
    run_model();
    load_program();
    run_and_wait();
    check_read("memory status", addr_ctrl, word_t'(1 << status_done));
    check_regs("memory");
  endtask

  task automatic test_control();
    prog.push_back(imm_word(op_addi, 0, 1, 7));
    prog.push_back(imm_word(op_addi, 0, 2, 7));
    prog.push_back(imm_word(op_beq, 1, 2, 6));
    // skipped by the taken beq
    prog.push_back(imm_word(op_addi, 0, 7, 1));
    prog.push_back(imm_word(op_addi, 0, 7, 2));
    prog.push_back(imm_word(op_addi, 0, 5, 3));
    prog.push_back(imm_word(op_addi, 0, 3, 33));
    prog.push_back(imm_word(op_bne, 1, 2, 12));
    prog.push_back(imm_word(op_addi, 0, 4, 44));
    prog.push_back(jump_word(12'd11));
    prog.push_back(imm_word(op_addi, 0, 5, 55));
    prog.push_back(imm_word(op_addi, 0, 6, 61));
    prog.push_back(halt_word);
    run_model();
    load_program();
    run_and_wait();
    check_read("control status", addr_ctrl, word_t'(1 << status_done));
    check_regs("control");
  endtask

  task automatic test_timeout();
    prog.push_back(jump_word(12'd0));
    load_program();
    run_and_wait();
    check_read("timeout status", addr_ctrl, word_t'(1 << status_timeout));
    check_read("timeout cycles", addr_cycles, word_t'(cycle_limit));
    if (complete !== 1'b1) report_error("complete is low after timeout");
  endtask

  task automatic test_bus_errors();
    word_t data;
    logic  err;
    apb_read(12'h008, data, err);
    if (err !== 1'b1) report_error("no pslverr on unmapped read");
    apb_write(addr_imem_base + 12'h004, nop_instr, err);
    if (err !== 1'b0) report_error("pslverr on valid imem write");
    // the loop at word 0 is still loaded and a halt there would end the run early
    start_run();
    apb_write(addr_imem_base, halt_word, err);
    if (err !== 1'b1) report_error("no pslverr on imem write while running");
    wait_complete();
    check_read("blocked write status", addr_ctrl, word_t'(1 << status_timeout));
    run_and_wait();
    check_read("rerun status", addr_ctrl, word_t'(1 << status_timeout));
    check_read("rerun cycles", addr_cycles, word_t'(cycle_limit));
  endtask

  initial begin
    errors  = 0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_arith();
    test_memory();
    test_control();
    test_timeout();
    test_bus_errors();
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter int imem_depth  = 64,
  parameter int dmem_depth  = 64,
  parameter int cycle_limit = 1000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  cpu_bus_pkg::apb_addr_t paddr,
  input  cpu_isa_pkg::word_t     pwdata,
  output cpu_isa_pkg::word_t     prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   complete
);
  import cpu_isa_pkg::*;

  logic      start, imem_we, core_run, core_restart, halted, limit_hit;
  logic [2:0] status;
  pc_t       imem_waddr;
  word_t     imem_wdata, dbg_data, cycles;
  reg_addr_t dbg_addr;

  apb_host_port #(.imem_depth(imem_depth)) u_host (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .running(core_run), .status(status), .cycles(cycles), .dbg_data(dbg_data),
    .start(start), .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
    .dbg_addr(dbg_addr)
  );

  run_control u_ctrl (
    .clk(clk), .reset(reset), .start(start), .halted(halted), .limit_hit(limit_hit),
    .core_run(core_run), .core_restart(core_restart), .complete(complete), .status(status)
  );

  cycle_timer #(.cycle_limit(cycle_limit)) u_timer (
    .clk(clk), .reset(reset), .core_run(core_run), .core_restart(core_restart),
    .cycles(cycles), .limit_hit(limit_hit)
  );

  cpu #(.imem_depth(imem_depth), .dmem_depth(dmem_depth)) u_cpu (
    .clk(clk), .reset(reset), .core_run(core_run), .core_restart(core_restart),
    .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
    .dbg_addr(dbg_addr), .dbg_data(dbg_data), .halted(halted)
  );

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu #(
  parameter int imem_depth = 64,
  parameter int dmem_depth = 64
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   core_run,
  input  logic                   core_restart,
  input  logic                   imem_we,
  input  cpu_isa_pkg::pc_t       imem_waddr,
  input  cpu_isa_pkg::word_t     imem_wdata,
  input  cpu_isa_pkg::reg_addr_t dbg_addr,
  output cpu_isa_pkg::word_t     dbg_data,
  output logic                   halted
);
  import cpu_isa_pkg::*;

  localparam int imem_aw = $clog2(imem_depth);

  word_t imem [imem_depth];
  pc_t   pc;
  word_t fetch_instr;
  logic  fetch_jump;
  logic  advance, stall, branch_taken;
  // ID
  word_t     if_id_instr, id_imm, id_rd1, id_rd2;
  opcode_e   id_op;
  reg_addr_t id_rs, id_rt, id_dst;
  logic      id_reg_write, id_use_rd, id_alu_src, id_mem_read, id_mem_write;
  logic      id_beq, id_bne, id_halt;
  alu_op_e   id_alu_op;
  // EX
  reg_addr_t id_ex_rs, id_ex_rt, id_ex_dst;
  word_t     id_ex_rd1, id_ex_rd2, id_ex_imm, ex_a, ex_b, ex_b_op, ex_result;
  logic      id_ex_reg_write, id_ex_alu_src, id_ex_mem_read, id_ex_mem_write;
  logic      id_ex_beq, id_ex_bne, id_ex_halt;
  alu_op_e   id_ex_alu_op;
  // MEM and WB
  word_t     ex_mem_alu, ex_mem_store, mem_read_data, mem_wb_alu, mem_wb_mem_data, wb_data;
  pc_t       ex_mem_target;
  reg_addr_t ex_mem_dst, mem_wb_dst;
  logic      ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_beq, ex_mem_bne;
  logic      ex_mem_eq, ex_mem_halt, mem_wb_reg_write, mem_wb_mem_read, mem_wb_halt;

  // restart cycle commits nothing
  assign advance = core_run & ~core_restart;

  ////////////////////
  // IF with jumps resolved here

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_waddr[imem_aw-1:0]] <= imem_wdata;
  end

  assign fetch_instr = imem[pc[imem_aw-1:0]];
  assign fetch_jump  = (opcode_e'(fetch_instr[opcode_msb:opcode_lsb]) == op_jmp);

  always_ff @(posedge clk) begin
    if (reset || core_restart) pc <= '0;
    else if (core_run) begin
      if (branch_taken) pc <= ex_mem_target;
      else if (!stall)  pc <= fetch_jump ? pc_t'(fetch_instr[jump_msb:0]) : pc + pc_t'(1);
    end
  end

  ////////////////////
  // ID decode and load-use hazard

  assign id_op  = opcode_e'(if_id_instr[opcode_msb:opcode_lsb]);
  assign id_rs  = if_id_instr[rs_msb:rs_lsb];
  assign id_rt  = if_id_instr[rt_msb:rt_lsb];
  assign id_dst = id_use_rd ? if_id_instr[rd_msb:rd_lsb] : id_rt;
  // zero extended
  assign id_imm = word_t'(if_id_instr[imm_msb:imm_lsb]);

  always_comb begin
    {id_reg_write, id_use_rd, id_alu_src, id_mem_read} = '0;
    {id_mem_write, id_beq, id_bne, id_halt}            = '0;
    id_alu_op = alu_add;
    case (id_op)
      op_add:  {id_reg_write, id_use_rd} = 2'b11;
      op_sub: begin
        {id_reg_write, id_use_rd} = 2'b11;
        id_alu_op = alu_sub;
      end
      op_and: begin
        {id_reg_write, id_use_rd} = 2'b11;
        id_alu_op = alu_and;
      end
      op_or: begin
        {id_reg_write, id_use_rd} = 2'b11;
        id_alu_op = alu_or;
      end
      op_slt: begin
        {id_reg_write, id_use_rd} = 2'b11;
        id_alu_op = alu_slt;
      end
      op_addi: {id_reg_write, id_alu_src} = 2'b11;
      op_lw:   {id_reg_write, id_alu_src, id_mem_read} = 3'b111;
      op_sw:   {id_alu_src, id_mem_write} = 2'b11;
      op_beq:  id_beq = 1'b1;
      op_bne:  id_bne = 1'b1;
      op_halt: id_halt = 1'b1;
      op_jmp, op_nop: ;
      default: ;
    endcase
  end

  assign stall = id_ex_mem_read && (id_ex_dst != '0) &&
                 (id_ex_dst == id_rs || id_ex_dst == id_rt);

  register_file u_regs (
    .clk(clk), .reset(reset),
    .write(mem_wb_reg_write & advance), .write_address(mem_wb_dst), .write_data(wb_data),
    .read_address_1(id_rs), .read_address_2(id_rt), .dbg_address(dbg_addr),
    .read_data_1(id_rd1), .read_data_2(id_rd2), .dbg_data(dbg_data)
  );

  ////////////////////
  // EX forwarding and ALU

  always_comb begin
    if (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_ex_rs)      ex_a = ex_mem_alu;
    else if (mem_wb_reg_write && mem_wb_dst != '0 && mem_wb_dst == id_ex_rs) ex_a = wb_data;
    else                                                                     ex_a = id_ex_rd1;
    if (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_ex_rt)      ex_b = ex_mem_alu;
    else if (mem_wb_reg_write && mem_wb_dst != '0 && mem_wb_dst == id_ex_rt) ex_b = wb_data;
    else                                                                     ex_b = id_ex_rd2;
  end

  assign ex_b_op = id_ex_alu_src ? id_ex_imm : ex_b;

  always_comb begin
    case (id_ex_alu_op)
      alu_sub: ex_result = ex_a - ex_b_op;
      alu_and: ex_result = ex_a & ex_b_op;
      alu_or:  ex_result = ex_a | ex_b_op;
      alu_slt: ex_result = word_t'($signed(ex_a) < $signed(ex_b_op));
      default: ex_result = ex_a + ex_b_op;
    endcase
  end

  ////////////////////
  // MEM and branch resolution

  assign branch_taken = (ex_mem_beq & ex_mem_eq) | (ex_mem_bne & ~ex_mem_eq);
  assign halted       = mem_wb_halt;
  assign wb_data      = mem_wb_mem_read ? mem_wb_mem_data : mem_wb_alu;

  // no store may retire alongside the halt
  data_memory #(.dmem_depth(dmem_depth)) u_dmem (
    .clk(clk), .write(ex_mem_mem_write & advance & ~halted), .read(ex_mem_mem_read),
    .address(ex_mem_alu), .write_data(ex_mem_store), .read_data(mem_read_data)
  );

  // pipeline control bits are cleared by bubbles and flushes
  always_ff @(posedge clk) begin
    if (reset || core_restart) begin
      if_id_instr <= nop_instr;
      {id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_beq, id_ex_bne} <= '0;
      id_ex_halt <= 1'b0;
      {ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_beq, ex_mem_bne} <= '0;
      ex_mem_halt <= 1'b0;
      {mem_wb_reg_write, mem_wb_mem_read, mem_wb_halt} <= '0;
    end else if (core_run) begin
      if (branch_taken)  if_id_instr <= nop_instr;
      else if (!stall)   if_id_instr <= fetch_instr;
      if (branch_taken || stall) begin
        {id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_beq, id_ex_bne} <= '0;
        id_ex_halt <= 1'b0;
      end else begin
        {id_ex_reg_write, id_ex_mem_read, id_ex_mem_write} <=
          {id_reg_write, id_mem_read, id_mem_write};
        {id_ex_beq, id_ex_bne, id_ex_halt} <= {id_beq, id_bne, id_halt};
      end
      if (branch_taken) begin
        {ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_beq, ex_mem_bne} <= '0;
        ex_mem_halt <= 1'b0;
      end else begin
        {ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write} <=
          {id_ex_reg_write, id_ex_mem_read, id_ex_mem_write};
        {ex_mem_beq, ex_mem_bne, ex_mem_halt} <= {id_ex_beq, id_ex_bne, id_ex_halt};
      end
      {mem_wb_reg_write, mem_wb_mem_read, mem_wb_halt} <=
        {ex_mem_reg_write, ex_mem_mem_read, ex_mem_halt};
    end
  end

  // payload is meaningful only with its control bits
  always_ff @(posedge clk) begin
    if (core_run) begin
      {id_ex_rs, id_ex_rt, id_ex_dst} <= {id_rs, id_rt, id_dst};
      {id_ex_rd1, id_ex_rd2, id_ex_imm} <= {id_rd1, id_rd2, id_imm};
      id_ex_alu_src   <= id_alu_src;
      id_ex_alu_op    <= id_alu_op;
      ex_mem_alu      <= ex_result;
      ex_mem_store    <= ex_b;
      ex_mem_dst      <= id_ex_dst;
      ex_mem_eq       <= (ex_a == ex_b);
      ex_mem_target   <= pc_t'(id_ex_imm);
      mem_wb_alu      <= ex_mem_alu;
      mem_wb_mem_data <= mem_read_data;
      mem_wb_dst      <= ex_mem_dst;
    end
  end

endmodule

// File: hw/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
  parameter int dmem_depth = 64
) (
  input  logic               clk,
  input  logic               write,
  input  logic               read,
  input  cpu_isa_pkg::word_t address,
  input  cpu_isa_pkg::word_t write_data,
  output cpu_isa_pkg::word_t read_data
);
  import cpu_isa_pkg::*;

  localparam int aw = $clog2(dmem_depth);

  word_t mem [dmem_depth];

  always_ff @(posedge clk) begin
    if (write) mem[address[aw-1:0]] <= write_data;
  end

  assign read_data = read ? mem[address[aw-1:0]] : '0;

  a_no_read_write: assert property (
    @(posedge clk) !$isunknown({read, write}) |-> !(read && write)
  );

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write,
  input  cpu_isa_pkg::reg_addr_t write_address,
  input  cpu_isa_pkg::reg_addr_t read_address_1,
  input  cpu_isa_pkg::reg_addr_t read_address_2,
  input  cpu_isa_pkg::reg_addr_t dbg_address,
  input  cpu_isa_pkg::word_t     write_data,
  output cpu_isa_pkg::word_t     read_data_1,
  output cpu_isa_pkg::word_t     read_data_2,
  output cpu_isa_pkg::word_t     dbg_data
);
  import cpu_isa_pkg::*;

  word_t regs [8];
  logic  write_live;

  // r0 is never written so it stays zero
  assign write_live = write && (write_address != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) regs[i] <= '0;
    end else if (write_live) begin
      regs[write_address] <= write_data;
    end
  end

  // write-first bypass for ID
  assign read_data_1 = (write_live && write_address == read_address_1) ? write_data
                                                                        : regs[read_address_1];
  assign read_data_2 = (write_live && write_address == read_address_2) ? write_data
                                                                        : regs[read_address_2];
  assign dbg_data    = regs[dbg_address];

endmodule

// File: hw/cycle_timer.sv
`timescale 1ns/1ps

module cycle_timer #(
  parameter int cycle_limit = 1000
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               core_run,
  input  logic               core_restart,
  output cpu_isa_pkg::word_t cycles,
  output logic               limit_hit
);
  import cpu_isa_pkg::*;

  word_t count;

  // saturates at the limit and holds after the run
  always_ff @(posedge clk) begin
    if (reset || core_restart) begin
      count <= '0;
    end else if (core_run && !limit_hit) begin
      count <= count + word_t'(1);
    end
  end

  assign limit_hit = (count == word_t'(cycle_limit));
  assign cycles    = count;

endmodule

// File: hw/run_control.sv
`timescale 1ns/1ps

module run_control (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       halted,
  input  logic       limit_hit,
  output logic       core_run,
  output logic       core_restart,
  output logic       complete,
  output logic [2:0] status
);
  import cpu_bus_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done,
    st_timeout
  } run_state_e;

  run_state_e state;
  logic       restart_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      restart_q <= 1'b0;
    end else begin
      restart_q <= 1'b0;
      case (state)
        st_run: begin
          // old halt and limit flags are stale during restart
          if (halted && !restart_q)         state <= st_done;
          else if (limit_hit && !restart_q) state <= st_timeout;
        end
        default: begin
          if (start) begin
            state     <= st_run;
            restart_q <= 1'b1;
          end
        end
      endcase
    end
  end

  assign core_run     = (state == st_run);
  assign core_restart = restart_q;
  assign complete     = (state == st_done) || (state == st_timeout);

  always_comb begin
    status                 = '0;
    status[status_running] = (state == st_run);
    status[status_done]    = (state == st_done);
    status[status_timeout] = (state == st_timeout);
  end

  // core and timer drop their end flags once the restart has cleared them
  a_restart_clears_flags: assert property (
    @(posedge clk) disable iff (reset) core_restart |=> !halted && !limit_hit
  );

endmodule

// File: hw/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port #(
  parameter int imem_depth = 64
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  cpu_bus_pkg::apb_addr_t  paddr,
  input  cpu_isa_pkg::word_t      pwdata,
  output cpu_isa_pkg::word_t      prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic                    running,
  input  logic [2:0]              status,
  input  cpu_isa_pkg::word_t      cycles,
  input  cpu_isa_pkg::word_t      dbg_data,
  output logic                    start,
  output logic                    imem_we,
  output cpu_isa_pkg::pc_t        imem_waddr,
  output cpu_isa_pkg::word_t      imem_wdata,
  output cpu_isa_pkg::reg_addr_t  dbg_addr
);
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  localparam int imem_span = 4 * imem_depth;

  logic access;
  logic hit_ctrl;
  logic hit_cycles;
  logic hit_reg;
  logic hit_imem;
  logic mapped;

  assign access     = psel & penable;
  assign hit_ctrl   = (paddr == addr_ctrl);
  assign hit_cycles = (paddr == addr_cycles);
  // eight word aligned registers
  assign hit_reg    = (paddr[1:0] == 2'b00) && (paddr >= addr_reg_base) &&
                      (int'(paddr) < int'(addr_reg_base) + 32);
  assign hit_imem   = (paddr[1:0] == 2'b00) && (paddr >= addr_imem_base) &&
                      (int'(paddr) < int'(addr_imem_base) + imem_span);

  // ctrl takes reads and writes while cycles and registers are read only and imem write only
  assign mapped  = pwrite ? (hit_ctrl | hit_imem) : (hit_ctrl | hit_cycles | hit_reg);
  assign pslverr = access & (~mapped | (pwrite & hit_imem & running));
  assign pready  = 1'b1;

  assign start      = access & pwrite & hit_ctrl & pwdata[0] & ~running;
  assign imem_we    = access & pwrite & hit_imem & ~running;
  assign imem_waddr = pc_t'((paddr - addr_imem_base) >> 2);
  assign imem_wdata = pwdata;
  assign dbg_addr   = reg_addr_t'((paddr - addr_reg_base) >> 2);

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_ctrl)        prdata = word_t'(status);
      else if (hit_cycles) prdata = cycles;
      else if (hit_reg)    prdata = dbg_data;
    end
  end

  // access phase must come from a selected transfer
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (reset) penable |-> psel
  );

endmodule

// File: hw/cpu_bus_pkg.sv
package cpu_bus_pkg;

  typedef logic [11:0] apb_addr_t;

  localparam apb_addr_t addr_ctrl      = 12'h000;
  localparam apb_addr_t addr_cycles    = 12'h004;
  localparam apb_addr_t addr_reg_base  = 12'h040;
  localparam apb_addr_t addr_imem_base = 12'h100;

  // status word bits
  localparam int status_running = 0;
  localparam int status_done    = 1;
  localparam int status_timeout = 2;

endpackage

// File: hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] pc_t;

  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_slt  = 4'h4,
    op_addi = 4'h5,
    op_lw   = 4'h6,
    op_sw   = 4'h7,
    op_beq  = 4'h8,
    op_bne  = 4'h9,
    op_jmp  = 4'ha,
    op_halt = 4'hb,
    op_nop  = 4'hf
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  // instruction fields
  localparam int opcode_msb = 15;
  localparam int opcode_lsb = 12;
  localparam int rs_msb     = 11;
  localparam int rs_lsb     = 9;
  localparam int rt_msb     = 8;
  localparam int rt_lsb     = 6;
  localparam int rd_msb     = 5;
  localparam int rd_lsb     = 3;
  localparam int imm_msb    = 5;
  localparam int imm_lsb    = 0;
  localparam int jump_msb   = 11;

  localparam word_t nop_instr = {op_nop, 12'h000};

endpackage
